/* fifo_pkg.sv */
// Shared FIFO defaults and the pointer width rule
package fifo_pkg;

  // ------------------------------
  // Default sizes
  // ------------------------------

  // Number of memory words, a power of two
  localparam int DEF_DEPTH = 16;

  // Payload width in bits
  localparam int DEF_WIDTH = 8;

  // Memory read latency in cycles, at least 2
  localparam int DEF_RD_LAT = 3;

  // Prefetch buffer size in words, at least 1
  localparam int DEF_PF_SIZE = 2;

  // ------------------------------
  // Pointer width rule
  // ------------------------------

  // Address bits for a memory of the given depth
  // Pointers carry one more bit above this for wrap detection
  // A depth of 1 still gets one address bit so slices stay legal
  function automatic int ptr_width(input int depth);
    if (depth > 1)
      return $clog2(depth);
    else
      return 1;
  endfunction

endpackage

/* fifo_head.sv */
// FIFO write side: write pointer, full detection, memory write port, usage count
module fifo_head
  import fifo_pkg::*;
#(
  parameter int depth = DEF_DEPTH,
  parameter int width = DEF_WIDTH,
  localparam int aw = ptr_width(depth)
)
(
  input  logic             clk,
  input  logic             reset,

  // Producer handshake
  input  logic             c_srdy,
  output logic             c_drdy,
  input  logic [width-1:0] c_data,

  // Read pointer from the buffered tail
  input  logic [aw:0]      rdptr,

  // Memory write port
  output logic             wr_en,
  output logic [aw-1:0]    wr_addr,
  output logic [width-1:0] wr_data,

  // Write pointer with wrap bit, and words held in memory
  output logic [aw:0]      wrptr,
  output logic [aw:0]      usage
);

  logic full;

  // ------------------------------
  // Full detection
  // ------------------------------

  // Same address, opposite wrap bit
  // Memory holds exactly depth words then
  assign full = (wrptr[aw] != rdptr[aw]) &&
                (wrptr[aw-1:0] == rdptr[aw-1:0]);

  // Producer may push whenever a slot is free
  assign c_drdy = !full;

  // ------------------------------
  // Memory write
  // ------------------------------

  // Word is written at the same edge it is accepted
  assign wr_en   = c_srdy && c_drdy;
  assign wr_addr = wrptr[aw-1:0];
  assign wr_data = c_data;

  // Pointer difference wraps modulo 2*depth, range 0..depth
  assign usage = wrptr - rdptr;

  // Write pointer advances with every accepted word
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wrptr <= '0;
    end
    else if (wr_en)
    begin
      wrptr <= wrptr + 1'b1;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  // Pointer gap never grows past the memory size
  // A write into a full memory or a read pointer running past the write pointer breaks this
  a_usage_bound : assert property (
    @(posedge clk) disable iff (reset)
    usage <= depth
  ) else $error("fifo_head: usage %0d above depth", usage);

endmodule

/* fifo_tail.sv */
// FIFO read side: read pointer, empty detection, memory read issue
module fifo_tail
  import fifo_pkg::*;
#(
  parameter int depth = DEF_DEPTH,
  localparam int aw = ptr_width(depth)
)
(
  input  logic          clk,
  input  logic          reset,

  // Write pointer, already delayed by the buffered tail
  input  logic [aw:0]   wrptr,

  // Room downstream for one more read
  input  logic          i_drdy,

  // Memory read port
  output logic          rd_en,
  output logic [aw-1:0] rd_addr,

  // Read pointer with wrap bit, back to the head
  output logic [aw:0]   rdptr
);

  logic          empty;
  logic [aw:0]   count;

  // ------------------------------
  // Empty detection
  // ------------------------------

  // Pointers equal including wrap bit
  assign empty = (wrptr == rdptr);

  // Words available to read, as seen here
  assign count = wrptr - rdptr;

  // ------------------------------
  // Read issue
  // ------------------------------

  // One read per cycle while data exists and the prefetch side has room
  assign rd_en   = !empty && i_drdy;
  assign rd_addr = rdptr[aw-1:0];

  // Slot is freed for the head as soon as the read is issued
  // Memory has already latched the word at that edge
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rdptr <= '0;
    end
    else if (rd_en)
    begin
      rdptr <= rdptr + 1'b1;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  // A read must target a written word, and the delayed write pointer
  // can never run more than depth ahead of the read pointer
  a_no_read_when_empty : assert property (
    @(posedge clk) disable iff (reset)
    rd_en |-> ((count != '0) && (count <= depth))
  ) else $error("fifo_tail: read with %0d words available", count);

endmodule

/* lat_mem.sv */
// Dual-port word memory with a fixed multi-cycle read pipeline
module lat_mem
  import fifo_pkg::*;
#(
  parameter int depth  = DEF_DEPTH,
  parameter int width  = DEF_WIDTH,
  parameter int rd_lat = DEF_RD_LAT,
  localparam int aw = ptr_width(depth)
)
(
  input  logic             clk,
  input  logic             reset,

  // Write port
  input  logic             wr_en,
  input  logic [aw-1:0]    wr_addr,
  input  logic [width-1:0] wr_data,

  // Read port
  input  logic             rd_en,
  input  logic [aw-1:0]    rd_addr,
  output logic [width-1:0] rd_data
);

  logic [width-1:0]  mem [depth];
  logic [width-1:0]  pipe [rd_lat];
  logic [rd_lat-1:0] vld;

  // ------------------------------
  // Storage
  // ------------------------------

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ------------------------------
  // Read pipeline
  // ------------------------------

  // Valid bits track which stages carry a read
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      vld <= '0;
    end
    else
    begin
      vld <= {vld[rd_lat-2:0], rd_en};
    end
  end

  // Stage 0 latches the array at the read edge
  // Later stages only move when the stage behind them holds a read
  always_ff @(posedge clk)
  begin
    if (rd_en)
      pipe[0] <= mem[rd_addr];
    for (int i = 1; i < rd_lat; i++)
    begin
      if (vld[i-1])
        pipe[i] <= pipe[i-1];
    end
  end

  // Last stage, valid rd_lat edges after the read; zero when idle
  assign rd_data = vld[rd_lat-1] ? pipe[rd_lat-1] : '0;

endmodule

/* fifo_buftail.sv */
// Buffered FIFO tail: delayed write pointer, in-flight read tracking, prefetch buffer
module fifo_buftail
  import fifo_pkg::*;
#(
  parameter int depth   = DEF_DEPTH,
  parameter int width   = DEF_WIDTH,
  parameter int rd_lat  = DEF_RD_LAT,
  parameter int pf_size = DEF_PF_SIZE,
  localparam int aw  = ptr_width(depth),
  localparam int pfw = (pf_size > 1) ? $clog2(pf_size) : 1,
  localparam int cw  = $clog2(pf_size + rd_lat + 1)
)
(
  input  logic             clk,
  input  logic             reset,

  // Pointer exchange with the head
  input  logic [aw:0]      wrptr,
  output logic [aw:0]      rdptr,

  // Memory read port
  output logic             rd_en,
  output logic [aw-1:0]    rd_addr,
  input  logic [width-1:0] rd_data,

  // Consumer handshake
  output logic             p_srdy,
  input  logic             p_drdy,
  output logic [width-1:0] p_data
);

  logic [aw:0]       wrptr_dly;
  logic              i_drdy;
  logic [rd_lat-1:0] d_rd_en;
  logic [width-1:0]  prefetch [pf_size];
  logic [pfw-1:0]    pf_hptr;
  logic [pfw-1:0]    pf_tptr;
  logic [cw-1:0]     pfusage;
  logic [cw-1:0]     inflight;
  logic [cw-1:0]     dyn_usage;
  logic              push;
  logic              pop;

  // Circular increment over pf_size slots
  function automatic logic [pfw-1:0] pf_inc(input logic [pfw-1:0] ptr);
    if (ptr == pfw'(pf_size - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  // ------------------------------
  // Read side pointer logic
  // ------------------------------

  // Sees the write pointer one cycle late, so a word is never read
  // in the same cycle it is written
  fifo_tail #(
    .depth  (depth)
  ) u_tail (
    .clk     (clk),
    .reset   (reset),
    .wrptr   (wrptr_dly),
    .i_drdy  (i_drdy),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rdptr   (rdptr)
  );

  // ------------------------------
  // Prefetch space accounting
  // ------------------------------

  // Reads issued whose data has not yet landed
  always_comb
  begin
    inflight = '0;
    for (int i = 0; i < rd_lat; i++)
      inflight = inflight + cw'(d_rd_en[i]);
  end

  // Every in-flight read has a reserved slot
  assign dyn_usage = pfusage + inflight;
  assign i_drdy    = (dyn_usage < cw'(pf_size));

  // Last delay stage lines up with rd_data from memory
  assign push = d_rd_en[rd_lat-1];
  assign pop  = p_srdy && p_drdy;

  // ------------------------------
  // Control registers
  // ------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wrptr_dly <= '0;
      d_rd_en   <= '0;
      pf_hptr   <= '0;
      pf_tptr   <= '0;
      pfusage   <= '0;
    end
    else
    begin
      wrptr_dly <= wrptr;
      d_rd_en   <= {d_rd_en[rd_lat-2:0], rd_en};
      if (pop)
        pf_hptr <= pf_inc(pf_hptr);
      if (push)
        pf_tptr <= pf_inc(pf_tptr);
      // Push and pop in one cycle leave the count as is
      pfusage <= pfusage + cw'(push) - cw'(pop);
    end
  end

  // ------------------------------
  // Prefetch storage and output
  // ------------------------------

  always_ff @(posedge clk)
  begin
    if (push)
      prefetch[pf_tptr] <= rd_data;
  end

  // Head slot stays put until popped, so p_data holds under stall
  assign p_srdy = (pfusage != '0);
  assign p_data = prefetch[pf_hptr];

  // Buffered words plus reads in flight never exceed the buffer,
  // which holds only while the tail issues reads under i_drdy
  a_pf_bound : assert property (
    @(posedge clk) disable iff (reset)
    dyn_usage <= cw'(pf_size)
  ) else $error("fifo_buftail: prefetch overcommitted, %0d of %0d", dyn_usage, pf_size);

endmodule

/* lat_fifo.sv */
// Top level FIFO: write head, latency memory and buffered read tail
module lat_fifo
  import fifo_pkg::*;
#(
  parameter int depth   = DEF_DEPTH,
  parameter int width   = DEF_WIDTH,
  parameter int rd_lat  = DEF_RD_LAT,
  parameter int pf_size = DEF_PF_SIZE,
  localparam int aw = ptr_width(depth)
)
(
  input  logic             clk,
  input  logic             reset,

  // Producer side
  input  logic             c_srdy,
  output logic             c_drdy,
  input  logic [width-1:0] c_data,

  // Consumer side
  output logic             p_srdy,
  input  logic             p_drdy,
  output logic [width-1:0] p_data,

  // Words held in memory, prefetch excluded
  output logic [aw:0]      usage
);

  logic             wr_en;
  logic [aw-1:0]    wr_addr;
  logic [width-1:0] wr_data;
  logic             rd_en;
  logic [aw-1:0]    rd_addr;
  logic [width-1:0] rd_data;
  logic [aw:0]      wrptr;
  logic [aw:0]      rdptr;

  // ------------------------------
  // Write side
  // ------------------------------

  fifo_head #(
    .depth (depth),
    .width (width)
  ) u_head (
    .clk     (clk),
    .reset   (reset),
    .c_srdy  (c_srdy),
    .c_drdy  (c_drdy),
    .c_data  (c_data),
    .rdptr   (rdptr),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wrptr   (wrptr),
    .usage   (usage)
  );

  // ------------------------------
  // Storage
  // ------------------------------

  lat_mem #(
    .depth  (depth),
    .width  (width),
    .rd_lat (rd_lat)
  ) u_mem (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // ------------------------------
  // Read side
  // ------------------------------

  fifo_buftail #(
    .depth   (depth),
    .width   (width),
    .rd_lat  (rd_lat),
    .pf_size (pf_size)
  ) u_buftail (
    .clk     (clk),
    .reset   (reset),
    .wrptr   (wrptr),
    .rdptr   (rdptr),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .p_srdy  (p_srdy),
    .p_drdy  (p_drdy),
    .p_data  (p_data)
  );

endmodule

/* fifo_tb.sv */
// Testbench for lat_fifo: file-driven records, scoreboard, capacity, usage and reset checks
module fifo_tb
  import fifo_pkg::*;
();

  localparam int AW         = ptr_width(DEF_DEPTH);
  localparam int SEED       = 32'h72da;
  localparam int RESET_CYC  = 8;
  localparam int WAIT_LIMIT = 4000;
  localparam int LOW_RUN    = 20;
  localparam int IDLE_CYC   = 20;

  logic                 clk;
  logic                 reset;
  logic                 c_srdy;
  logic                 c_drdy;
  logic [DEF_WIDTH-1:0] c_data;
  logic                 p_srdy;
  logic                 p_drdy;
  logic [DEF_WIDTH-1:0] p_data;
  logic [AW:0]          usage;

  // Scoreboard of accepted words, oldest first
  logic [DEF_WIDTH-1:0] sb [$];
  logic [DEF_WIDTH-1:0] exp_word;
  logic [DEF_WIDTH-1:0] held_data;
  logic                 stall_seen;
  int                   data_errs;
  int                   check_errs;
  int                   timeouts;

  lat_fifo #(
    .depth   (DEF_DEPTH),
    .width   (DEF_WIDTH),
    .rd_lat  (DEF_RD_LAT),
    .pf_size (DEF_PF_SIZE)
  ) uut (
    .clk    (clk),
    .reset  (reset),
    .c_srdy (c_srdy),
    .c_drdy (c_drdy),
    .c_data (c_data),
    .p_srdy (p_srdy),
    .p_drdy (p_drdy),
    .p_data (p_data),
    .usage  (usage)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------
  // Monitor
  // ------------------------------

  // Falling edge sees settled values; a handshake seen here completes at the next rising edge
  always @(negedge clk)
  begin
    if (reset)
    begin
      stall_seen = 1'b0;
    end
    else
    begin
      // Stalled output must hold its word
      if (stall_seen)
      begin
        if (!p_srdy)
        begin
          $display("ERROR %0t: p_srdy dropped while the consumer was stalling", $time);
          data_errs++;
        end
        else if (p_data !== held_data)
        begin
          $display("ERROR %0t: p_data expected %0h got %0h", $time, held_data, p_data);
          data_errs++;
        end
      end
      if (p_srdy && p_drdy)
      begin
        if (sb.size() == 0)
        begin
          $display("ERROR %0t: a word left the FIFO when none was expected", $time);
          data_errs++;
        end
        else
        begin
          exp_word = sb.pop_front();
          if (p_data !== exp_word)
          begin
            $display("ERROR %0t: p_data expected %0h got %0h", $time, exp_word, p_data);
            data_errs++;
          end
        end
      end
      if (c_srdy && c_drdy)
        sb.push_back(c_data);
      stall_seen = p_srdy && !p_drdy;
      held_data  = p_data;
    end
  end

  // ------------------------------
  // Stimulus tasks
  // ------------------------------

  task automatic apply_reset();
    @(posedge clk);
    #1;
    reset = 1'b1;
    repeat (RESET_CYC) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  // Offers random words until n are taken; idle_pct of cycles stay idle
  task automatic produce(input int n, input int idle_pct, output int sent);
    int guard;
    sent  = 0;
    guard = 0;
    while (sent < n && guard < WAIT_LIMIT)
    begin
      @(posedge clk);
      #1;
      if (int'($urandom % 100) < idle_pct)
        c_srdy = 1'b0;
      else
      begin
        c_srdy = 1'b1;
        c_data = DEF_WIDTH'($urandom);
      end
      @(negedge clk);
      if (c_srdy && c_drdy)
        sent++;
      guard++;
    end
    @(posedge clk);
    #1;
    c_srdy = 1'b0;
    if (sent < n)
    begin
      $display("Producer timed out at %0t after %0d of %0d words", $time, sent, n);
      timeouts++;
    end
  endtask

  // Takes n words, stalling stall_pct of cycles
  task automatic consume(input int n, input int stall_pct, output int got);
    int guard;
    got   = 0;
    guard = 0;
    while (got < n && guard < WAIT_LIMIT)
    begin
      @(posedge clk);
      #1;
      p_drdy = (int'($urandom % 100) >= stall_pct);
      @(negedge clk);
      if (p_srdy && p_drdy)
        got++;
      guard++;
    end
    @(posedge clk);
    #1;
    p_drdy = 1'b0;
    if (got < n)
    begin
      $display("Consumer timed out at %0t after %0d of %0d words", $time, got, n);
      timeouts++;
    end
  endtask

  // Both sides at once, then every accepted word must have left
  task automatic run_stream(input int n, input int idle_pct, input int stall_pct);
    int sent;
    int got;
    fork
      produce(n, idle_pct, sent);
      consume(n, stall_pct, got);
    join
    repeat (2) @(posedge clk);
    if (got != sent)
    begin
      $display("ERROR %0t: words out expected %0d got %0d", $time, sent, got);
      check_errs++;
    end
    if (sb.size() != 0)
    begin
      $display("%0d accepted words never left the FIFO", sb.size());
      check_errs++;
    end
  endtask

  // Push against a stalled consumer until c_drdy stays low, then drain everything
  task automatic fill_and_drain(input int limit, input int idle_pct, input int stall_pct,
                                input int exp_cap);
    int sent;
    int got;
    int low_run;
    int guard;
    sent    = 0;
    low_run = 0;
    guard   = 0;
    p_drdy  = 1'b0;
    while (low_run < LOW_RUN && sent < limit && guard < WAIT_LIMIT)
    begin
      @(posedge clk);
      #1;
      c_srdy = (int'($urandom % 100) >= idle_pct);
      c_data = DEF_WIDTH'($urandom);
      @(negedge clk);
      if (c_srdy && c_drdy)
        sent++;
      if (!c_drdy)
        low_run++;
      else
        low_run = 0;
      guard++;
    end
    @(posedge clk);
    #1;
    c_srdy = 1'b0;
    if (low_run < LOW_RUN)
    begin
      $display("c_drdy never stayed low for %0d cycles during the fill", LOW_RUN);
      timeouts++;
    end
    if (sent != exp_cap)
    begin
      $display("ERROR %0t: accepted words expected %0d got %0d", $time, exp_cap, sent);
      check_errs++;
    end
    @(negedge clk);
    if (int'(usage) != DEF_DEPTH)
    begin
      $display("ERROR %0t: usage expected %0d got %0d", $time, DEF_DEPTH, usage);
      check_errs++;
    end
    consume(sent, stall_pct, got);
    repeat (IDLE_CYC) @(posedge clk);
    @(negedge clk);
    if (usage != '0)
    begin
      $display("ERROR %0t: usage expected 0 got %0d", $time, usage);
      check_errs++;
    end
    if (p_srdy !== 1'b0)
    begin
      $display("ERROR %0t: p_srdy expected 0 got %0b", $time, p_srdy);
      check_errs++;
    end
    if (sb.size() != 0)
    begin
      $display("%0d words were left behind after the drain", sb.size());
      check_errs++;
    end
  endtask

  // Load words, reset under them, then check a fresh stream
  task automatic reset_midstream(input int n, input int idle_pct, input int stall_pct);
    int sent;
    p_drdy = 1'b0;
    produce(n, idle_pct, sent);
    apply_reset();
    @(negedge clk);
    if (p_srdy !== 1'b0)
    begin
      $display("ERROR %0t: p_srdy expected 0 got %0b", $time, p_srdy);
      check_errs++;
    end
    if (usage != '0)
    begin
      $display("ERROR %0t: usage expected 0 got %0d", $time, usage);
      check_errs++;
    end
    sb.delete();
    run_stream(n, idle_pct, stall_pct);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial
  begin
    int    fd;
    int    r;
    int    n_rec;
    int    mode;
    int    count;
    int    idle;
    int    stall;
    int    exp_cap;
    string tok;
    string rest;
    c_srdy     = 1'b0;
    c_data     = '0;
    p_drdy     = 1'b0;
    reset      = 1'b1;
    stall_seen = 1'b0;
    held_data  = '0;
    data_errs  = 0;
    check_errs = 0;
    timeouts   = 0;
    n_rec      = 0;
    void'($urandom(SEED));
    apply_reset();
    fd = $fopen("fifo_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open fifo_tests.txt, no records were run");
      check_errs++;
    end
    else
    begin
      while ($fscanf(fd, "%s", tok) == 1)
      begin
        // Comment line, skip the rest of it
        if (tok.substr(0, 0) == "#")
          r = $fgets(rest, fd);
        else
        begin
          r = $sscanf(tok, "%d", mode);
          r = r + $fscanf(fd, "%d %d %d %d", count, idle, stall, exp_cap);
          if (r != 5)
          begin
            $display("Malformed record after %0d good records", n_rec);
            check_errs++;
          end
          else
          begin
            n_rec++;
            $display("Record %0d: mode %0d, %0d words, idle %0d%%, stall %0d%%",
                     n_rec, mode, count, idle, stall);
            case (mode)
              0, 1: run_stream(count, idle, stall);
              2: fill_and_drain(count, idle, stall, exp_cap);
              3: reset_midstream(count, idle, stall);
              default:
              begin
                $display("Record %0d has unknown mode %0d", n_rec, mode);
                check_errs++;
              end
            endcase
            repeat (4) @(posedge clk);
          end
        end
      end
      $fclose(fd);
      if (n_rec == 0)
      begin
        $display("The test file holds no records");
        check_errs++;
      end
    end
    $display("Summary: %0d records, %0d data errors, %0d check errors, %0d timeouts",
             n_rec, data_errs, check_errs, timeouts);
    if (data_errs + check_errs + timeouts == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

/* fifo_tests.txt */
# Columns: mode count idle_pct stall_pct exp_cap
# Modes: 0 full-rate stream, 1 random gaps and stalls, 2 fill then drain, 3 reset mid-stream
# exp_cap is the capacity expected in mode 2, 0 elsewhere
# In mode 2 the count column only bounds the number of words offered

# Full rate on both sides
0 64 0 0 0
0 5 0 0 0

# Random producer gaps and consumer stalls
1 100 20 20 0
1 100 50 10 0
1 100 10 50 0
1 80 70 70 0
1 60 0 80 0
1 60 80 0 0

# Capacity: depth 16 plus prefetch 2
2 40 0 0 18
2 40 30 40 18

# Reset while words sit in memory and prefetch
3 10 0 0 0
3 18 20 30 0

# One more mixed stream after the resets
1 120 30 30 0

/* list.f */
fifo_pkg.sv
fifo_head.sv
fifo_tail.sv
lat_mem.sv
fifo_buftail.sv
lat_fifo.sv
fifo_tb.sv

/* Makefile */
# Verilator build and run for the latency FIFO

VERILATOR ?= verilator
TOP       ?= fifo_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Test failures found

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES) fifo_tests.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "FAIL: simulator exit status $$status"; exit 1; fi; \
	echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
